//--- flist.f
source/isa_pkg.sv
source/stage_pkg.sv
source/exu_alu.sv
source/exu_branch.sv
source/exu_mem_csr.sv
source/exu_stage_reg.sv
source/exu.sv
testbench/tb_exu.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_exu -f flist.f

out=$(./obj_dir/Vtb_exu)
echo "$out"

if echo "$out" | grep -qx "Regression passed"; then
	exit 0
fi
exit 1

//--- source/exu.sv
`timescale 1ns/1ps
`default_nettype none

module exu (
	input  wire                       clock,
	input  wire                       rst_n,

	input  wire stage_pkg::exec_req_t req,
	input  wire                       exu_valid,
	output wire                       exu_ready,

	output wire stage_pkg::exec_res_t res,
	output wire                       lsu_valid,
	input  wire                       lsu_ready,

	output wire                       jump_wrong
);

	isa_pkg::word_t       alu_val;
	isa_pkg::word_t       next_jump_addr;
	logic                 next_jump_wrong;
	isa_pkg::wmask_t      wmask;
	isa_pkg::word_t       lsu_data;
	isa_pkg::word_t       csr_wdata;
	logic                 lsu_ren;
	logic                 lsu_wen;
	logic                 csr_enable;
	stage_pkg::exec_res_t next_res;

	exu_alu i_alu (
		.req     (req),
		.alu_val (alu_val)
	);

	exu_branch i_branch (
		.req             (req),
		.alu_val         (alu_val),
		.next_jump_addr  (next_jump_addr),
		.next_jump_wrong (next_jump_wrong)
	);

	exu_mem_csr i_mem_csr (
		.req        (req),
		.wmask      (wmask),
		.lsu_data   (lsu_data),
		.csr_wdata  (csr_wdata),
		.lsu_ren    (lsu_ren),
		.lsu_wen    (lsu_wen),
		.csr_enable (csr_enable)
	);

	always_comb begin
		next_res            = '0;
		next_res.csr_val    = req.csr_val;
		next_res.pc         = req.pc;
		next_res.rd         = req.rd;
		next_res.val        = alu_val;
		next_res.csr_wdata  = csr_wdata;
		next_res.wmask      = wmask;
		next_res.lsu_data   = lsu_data;
		next_res.funct3     = req.funct3;
		next_res.csr_addr   = req.imm[11:0]; // csr number sits in the i-type immediate
		next_res.reg_wen    = req.reg_wen;
		next_res.lsu_ren    = lsu_ren;
		next_res.lsu_wen    = lsu_wen;
		next_res.csr_enable = csr_enable;
		next_res.jal_enable = req.op_class[isa_pkg::class_jal] | req.op_class[isa_pkg::class_jalr];
		next_res.ecall      = req.ecall;
		next_res.jump_addr  = next_jump_addr;
	end

	exu_stage_reg i_stage_reg (
		.clock           (clock),
		.rst_n           (rst_n),
		.exu_valid       (exu_valid),
		.exu_ready       (exu_ready),
		.lsu_valid       (lsu_valid),
		.lsu_ready       (lsu_ready),
		.next_res        (next_res),
		.next_jump_wrong (next_jump_wrong),
		.res             (res),
		.jump_wrong      (jump_wrong)
	);

endmodule

`default_nettype wire

//--- source/exu_alu.sv
`timescale 1ns/1ps
`default_nettype none

module exu_alu (
	input  wire stage_pkg::exec_req_t req,
	output isa_pkg::word_t            alu_val
);

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_xor,
		alu_or,
		alu_srl,
		alu_sra,
		alu_sll,
		alu_slt,
		alu_sltu
	} alu_op_e;

	isa_pkg::word_t              lop;
	isa_pkg::word_t              rop;
	logic [isa_pkg::shamt_w-1:0] shamt;
	logic                        arith;
	logic                        alt;
	alu_op_e                     op;

	always_comb begin
		if (req.op_class[isa_pkg::class_auipc] | req.op_class[isa_pkg::class_jal] |
				req.op_class[isa_pkg::class_branch]) begin
			lop = req.pc; // pc-relative targets
		end else if (req.op_class[isa_pkg::class_lui]) begin
			lop = '0;
		end else begin
			lop = req.src1;
		end
	end

	assign rop   = req.op_class[isa_pkg::class_op] ? req.src2 : req.imm;
	assign shamt = rop[isa_pkg::shamt_w-1:0];
	assign arith = req.op_class[isa_pkg::class_op] | req.op_class[isa_pkg::class_opimm];
	assign alt   = req.funct7[isa_pkg::f7_alt_bit];

	// everything outside op/op-imm is an add
	always_comb begin
		op = alu_add;
		if (arith) begin
			case (req.funct3)
				isa_pkg::f3_add_sub: op = (req.op_class[isa_pkg::class_op] & alt) ? alu_sub : alu_add;
				isa_pkg::f3_sll:     op = alu_sll;
				isa_pkg::f3_slt:     op = alu_slt;
				isa_pkg::f3_sltu:    op = alu_sltu;
				isa_pkg::f3_xor:     op = alu_xor;
				isa_pkg::f3_srl_sra: op = alt ? alu_sra : alu_srl; // srai carries funct7 in imm
				isa_pkg::f3_or:      op = alu_or;
				isa_pkg::f3_and:     op = alu_and;
				default:             op = alu_add;
			endcase
		end
	end

	always_comb begin
		case (op)
			alu_add:  alu_val = lop + rop;
			alu_sub:  alu_val = lop - rop;
			alu_and:  alu_val = lop & rop;
			alu_xor:  alu_val = lop ^ rop;
			alu_or:   alu_val = lop | rop;
			alu_srl:  alu_val = lop >> shamt;
			alu_sra:  alu_val = isa_pkg::word_t'($signed(lop) >>> shamt);
			alu_sll:  alu_val = lop << shamt;
			alu_slt:  alu_val = {31'b0, $signed(lop) < $signed(rop)};
			alu_sltu: alu_val = {31'b0, lop < rop};
			default:  alu_val = lop + rop;
		endcase
	end

endmodule

`default_nettype wire

//--- source/exu_branch.sv
`timescale 1ns/1ps
`default_nettype none

module exu_branch (
	input  wire stage_pkg::exec_req_t req,
	input  wire isa_pkg::word_t       alu_val,
	output isa_pkg::word_t            next_jump_addr,
	output logic                      next_jump_wrong
);

	isa_pkg::word_t snpc;
	logic           cond;
	logic           jump_en;

	assign snpc = req.pc + isa_pkg::inst_bytes;

	// compares registers, alu is busy with the target
	always_comb begin
		case (req.funct3)
			isa_pkg::f3_beq:  cond = (req.src1 == req.src2);
			isa_pkg::f3_bne:  cond = (req.src1 != req.src2);
			isa_pkg::f3_blt:  cond = ($signed(req.src1) < $signed(req.src2));
			isa_pkg::f3_bge:  cond = ($signed(req.src1) >= $signed(req.src2));
			isa_pkg::f3_bltu: cond = (req.src1 < req.src2);
			isa_pkg::f3_bgeu: cond = (req.src1 >= req.src2);
			default:          cond = 1'b0;
		endcase
	end

	assign jump_en = req.op_class[isa_pkg::class_jal] | req.op_class[isa_pkg::class_jalr] |
		(req.op_class[isa_pkg::class_branch] & cond);

	always_comb begin
		if (req.csr_jump_en) begin
			next_jump_addr = req.csr_jump; // ecall / mret redirect wins
		end else if (jump_en) begin
			next_jump_addr = alu_val;
		end else begin
			next_jump_addr = snpc;
		end
	end

	// fetch always guesses pc+4
	assign next_jump_wrong = (next_jump_addr != snpc);

endmodule

`default_nettype wire

//--- source/exu_mem_csr.sv
`timescale 1ns/1ps
`default_nettype none

module exu_mem_csr (
	input  wire stage_pkg::exec_req_t req,
	output isa_pkg::wmask_t           wmask,
	output isa_pkg::word_t            lsu_data,
	output isa_pkg::word_t            csr_wdata,
	output logic                      lsu_ren,
	output logic                      lsu_wen,
	output logic                      csr_enable
);

	always_comb begin
		case (req.funct3[1:0])
			isa_pkg::size_byte: wmask = 4'b0001;
			isa_pkg::size_half: wmask = 4'b0011;
			isa_pkg::size_word: wmask = 4'b1111;
			default:            wmask = 4'b0000;
		endcase
	end

	assign lsu_data = req.src2; // unshifted, lsu aligns
	assign lsu_ren  = req.op_class[isa_pkg::class_load];
	assign lsu_wen  = req.op_class[isa_pkg::class_store];

	// funct3 000 is ecall/mret, no csr write
	assign csr_enable = req.op_class[isa_pkg::class_csr] & (req.funct3 != 3'b000);

	always_comb begin
		case (req.funct3)
			isa_pkg::f3_csrrw: csr_wdata = req.src1;
			isa_pkg::f3_csrrs: csr_wdata = req.src1 | req.csr_val;
			default:           csr_wdata = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- source/exu_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module exu_stage_reg (
	input  wire                       clock,
	input  wire                       rst_n,

	input  wire                       exu_valid,
	output logic                      exu_ready,
	output logic                      lsu_valid,
	input  wire                       lsu_ready,

	input  wire stage_pkg::exec_res_t next_res,
	input  wire                       next_jump_wrong,
	output stage_pkg::exec_res_t      res,
	output logic                      jump_wrong
);

	typedef enum logic {
		stage_empty,
		stage_full
	} stage_state_e;

	stage_state_e state;
	stage_state_e state_next;
	logic         accept;
	logic         release_res;

	// single slot, no overlap of accept and release
	assign exu_ready   = (state == stage_empty);
	assign lsu_valid   = (state == stage_full);
	assign accept      = exu_valid & exu_ready;
	assign release_res = lsu_valid & lsu_ready;

	always_comb begin
		state_next = state;
		case (state)
			stage_empty: begin
				if (accept) begin
					state_next = stage_full;
				end
			end
			stage_full: begin
				if (release_res) begin
					state_next = stage_empty;
				end
			end
			default: state_next = stage_empty;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state      <= stage_empty;
			jump_wrong <= 1'b0;
		end else begin
			state      <= state_next;
			jump_wrong <= accept & next_jump_wrong; // one cycle, independent of lsu_ready
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			res <= next_res;
		end
	end

endmodule

`default_nettype wire

//--- source/isa_pkg.sv
`default_nettype none

package isa_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0]  reg_idx_t;  // rv32e, 16 registers
	typedef logic [2:0]  funct3_t;
	typedef logic [6:0]  funct7_t;
	typedef logic [9:0]  op_class_t; // one-hot
	typedef logic [3:0]  wmask_t;
	typedef logic [11:0] csr_addr_t;

	// one-hot positions in op_class_t
	localparam int class_lui    = 0;
	localparam int class_auipc  = 1;
	localparam int class_jal    = 2;
	localparam int class_jalr   = 3;
	localparam int class_branch = 4;
	localparam int class_load   = 5;
	localparam int class_store  = 6;
	localparam int class_opimm  = 7;
	localparam int class_op     = 8;
	localparam int class_csr    = 9;

	localparam funct3_t f3_add_sub = 3'b000;
	localparam funct3_t f3_sll     = 3'b001;
	localparam funct3_t f3_slt     = 3'b010;
	localparam funct3_t f3_sltu    = 3'b011;
	localparam funct3_t f3_xor     = 3'b100;
	localparam funct3_t f3_srl_sra = 3'b101;
	localparam funct3_t f3_or      = 3'b110;
	localparam funct3_t f3_and     = 3'b111;

	localparam funct3_t f3_beq  = 3'b000;
	localparam funct3_t f3_bne  = 3'b001;
	localparam funct3_t f3_blt  = 3'b100;
	localparam funct3_t f3_bge  = 3'b101;
	localparam funct3_t f3_bltu = 3'b110;
	localparam funct3_t f3_bgeu = 3'b111;

	localparam funct3_t f3_csrrw = 3'b001;
	localparam funct3_t f3_csrrs = 3'b010;

	// access size, funct3[1:0] of load/store
	localparam logic [1:0] size_byte = 2'b00;
	localparam logic [1:0] size_half = 2'b01;
	localparam logic [1:0] size_word = 2'b10;

	localparam int    f7_alt_bit = 5; // sub / sra select
	localparam int    shamt_w    = 5;
	localparam word_t inst_bytes = 32'd4;

endpackage

`default_nettype wire

//--- source/stage_pkg.sv
`default_nettype none

package stage_pkg;

	// decode -> execute
	typedef struct packed {
		isa_pkg::op_class_t op_class;
		isa_pkg::reg_idx_t  rd;
		isa_pkg::word_t     src1;
		isa_pkg::word_t     src2;
		isa_pkg::word_t     imm;
		isa_pkg::funct3_t   funct3;
		isa_pkg::funct7_t   funct7;
		isa_pkg::word_t     pc;
		isa_pkg::word_t     csr_val;     // current value of the addressed csr
		logic               reg_wen;
		logic               ecall;
		logic               csr_jump_en; // trap entry or mret
		isa_pkg::word_t     csr_jump;
	} exec_req_t;

	// execute -> memory
	typedef struct packed {
		isa_pkg::word_t     csr_val;
		isa_pkg::word_t     pc;
		isa_pkg::reg_idx_t  rd;
		isa_pkg::word_t     val;       // alu result or memory address
		isa_pkg::word_t     csr_wdata;
		isa_pkg::wmask_t    wmask;
		isa_pkg::word_t     lsu_data;
		isa_pkg::funct3_t   funct3;    // load width and sign for the lsu

		isa_pkg::csr_addr_t csr_addr;

		logic               reg_wen;
		logic               lsu_ren;
		logic               lsu_wen;
		logic               csr_enable;
		logic               jal_enable; // writeback takes pc+4
		logic               ecall;

		isa_pkg::word_t     jump_addr;
	} exec_res_t;

endpackage

`default_nettype wire

//--- testbench/tb_exu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exu;

	localparam int max_txn    = 160; // about 134 requests over all tests
	localparam int txn_cycles = 25;  // send, longest stall, release
	localparam int max_cycles = max_txn * txn_cycles;

	// equal, less and greater pairs, then pairs where signed and unsigned order disagree
	localparam isa_pkg::word_t lhs_vals [5] = '{32'h1234_5678, 32'd5, 32'd9,
		32'hffff_fff0, 32'd3};
	localparam isa_pkg::word_t rhs_vals [5] = '{32'h1234_5678, 32'd9, 32'd5,
		32'd3, 32'hffff_fff0};

	logic                 clock = 1'b0;
	logic                 rst_n;
	stage_pkg::exec_req_t req;
	logic                 exu_valid;
	logic                 exu_ready;
	stage_pkg::exec_res_t res;
	logic                 lsu_valid;
	logic                 lsu_ready;
	logic                 jump_wrong;

	logic [31:0] seed   = 32'hd4c648f6;
	int          cycles = 0;
	int          errors = 0;
	int          test_errors;
	int          passed = 0;
	int          failed = 0;

	exu i_dut (
		.clock      (clock),
		.rst_n      (rst_n),
		.req        (req),
		.exu_valid  (exu_valid),
		.exu_ready  (exu_ready),
		.res        (res),
		.lsu_valid  (lsu_valid),
		.lsu_ready  (lsu_ready),
		.jump_wrong (jump_wrong)
	);

	always #20 clock = ~clock;

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout after %0d cycles, the DUT stopped handshaking", cycles);
			$display("Regression failed");
			$finish;
		end
	end

	function automatic logic [31:0] rand32();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic isa_pkg::word_t model_alu(input stage_pkg::exec_req_t r);
		isa_pkg::word_t a;
		isa_pkg::word_t b;
		logic [4:0]     sh;
		a = r.op_class[isa_pkg::class_lui] ? 32'd0 : r.src1;
		if (r.op_class[isa_pkg::class_auipc] || r.op_class[isa_pkg::class_jal] ||
				r.op_class[isa_pkg::class_branch]) begin
			a = r.pc;
		end
		b  = r.op_class[isa_pkg::class_op] ? r.src2 : r.imm;
		sh = b[4:0];
		if (!r.op_class[isa_pkg::class_op] && !r.op_class[isa_pkg::class_opimm]) begin
			return a + b; // addresses and targets
		end
		case (r.funct3)
			3'd0: return (r.op_class[isa_pkg::class_op] && r.funct7[5]) ? a - b : a + b;
			3'd1: return a << sh;
			3'd2: return {31'd0, $signed(a) < $signed(b)};
			3'd3: return {31'd0, a < b};
			3'd4: return a ^ b;
			3'd5: return r.funct7[5] ? 32'($signed(a) >>> sh) : a >> sh;
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_taken(input stage_pkg::exec_req_t r);
		case (r.funct3)
			3'd0: return r.src1 == r.src2;
			3'd1: return r.src1 != r.src2;
			3'd4: return $signed(r.src1) < $signed(r.src2);
			3'd5: return $signed(r.src1) >= $signed(r.src2);
			3'd6: return r.src1 < r.src2;
			3'd7: return r.src1 >= r.src2;
			default: return 1'b0;
		endcase
	endfunction

	function automatic stage_pkg::exec_res_t model(input stage_pkg::exec_req_t r);
		stage_pkg::exec_res_t e;
		logic                 jump;
		e          = '0;
		e.csr_val  = r.csr_val;
		e.pc       = r.pc;
		e.rd       = r.rd;
		e.val      = model_alu(r);
		e.funct3   = r.funct3;
		e.csr_addr = r.imm[11:0];
		e.reg_wen  = r.reg_wen;
		e.ecall    = r.ecall;
		e.lsu_data = r.src2;
		e.lsu_ren  = r.op_class[isa_pkg::class_load];
		e.lsu_wen  = r.op_class[isa_pkg::class_store];
		e.wmask    = (r.funct3[1:0] == 2'd0) ? 4'h1 : (r.funct3[1:0] == 2'd1) ? 4'h3 :
			(r.funct3[1:0] == 2'd2) ? 4'hf : 4'h0;
		e.csr_enable = r.op_class[isa_pkg::class_csr] && (r.funct3 != 3'd0);
		e.csr_wdata  = (r.funct3 == isa_pkg::f3_csrrw) ? r.src1 :
			(r.funct3 == isa_pkg::f3_csrrs) ? (r.src1 | r.csr_val) : 32'd0;
		e.jal_enable = r.op_class[isa_pkg::class_jal] || r.op_class[isa_pkg::class_jalr];
		jump = e.jal_enable || (r.op_class[isa_pkg::class_branch] && branch_taken(r));
		e.jump_addr = r.csr_jump_en ? r.csr_jump : jump ? e.val : r.pc + 32'd4;
		return e;
	endfunction

	function automatic stage_pkg::exec_req_t make_req(input int cls, input int f3,
			input logic alt, input isa_pkg::word_t a, input isa_pkg::word_t b,
			input isa_pkg::word_t imm);
		stage_pkg::exec_req_t r;
		isa_pkg::word_t       bits;
		bits       = rand32();
		r          = '0;
		r.op_class = isa_pkg::op_class_t'(1) << cls;
		r.funct3   = isa_pkg::funct3_t'(f3);
		r.funct7   = {1'b0, alt, 5'd0};
		r.src1     = a;
		r.src2     = b;
		r.imm      = imm;
		r.rd       = bits[3:0];
		r.reg_wen  = bits[4];
		r.pc       = rand32() & 32'hffff_fffc;
		r.csr_val  = rand32();
		return r;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_res(input stage_pkg::exec_res_t e);
		check_value("res.val", res.val, e.val);
		check_value("res.jump_addr", res.jump_addr, e.jump_addr);
		check_value("res.pc", res.pc, e.pc);
		check_value("res.csr_val", res.csr_val, e.csr_val);
		check_value("res.csr_wdata", res.csr_wdata, e.csr_wdata);
		check_value("res.lsu_data", res.lsu_data, e.lsu_data);
		check_value("res.rd", 32'(res.rd), 32'(e.rd));
		check_value("res.wmask", 32'(res.wmask), 32'(e.wmask));
		check_value("res.funct3", 32'(res.funct3), 32'(e.funct3));
		check_value("res.csr_addr", 32'(res.csr_addr), 32'(e.csr_addr));
		check_value("res.reg_wen", 32'(res.reg_wen), 32'(e.reg_wen));
		check_value("res.lsu_ren", 32'(res.lsu_ren), 32'(e.lsu_ren));
		check_value("res.lsu_wen", 32'(res.lsu_wen), 32'(e.lsu_wen));
		check_value("res.csr_enable", 32'(res.csr_enable), 32'(e.csr_enable));
		check_value("res.jal_enable", 32'(res.jal_enable), 32'(e.jal_enable));
		check_value("res.ecall", 32'(res.ecall), 32'(e.ecall));
	endtask

	// one request through the stage with lsu_ready low for hold cycles
	task automatic run_txn(input stage_pkg::exec_req_t r, input int hold);
		stage_pkg::exec_res_t e;
		logic                 jw;
		int                   waits;
		e  = model(r);
		jw = (e.jump_addr != r.pc + 32'd4);
		@(posedge clock);
		req       <= r;
		exu_valid <= 1'b1;
		lsu_ready <= 1'b0;
		@(negedge clock);
		check_value("jump_wrong", 32'(jump_wrong), 32'd0); // not yet accepted
		waits = 0;
		while (!lsu_valid) begin
			@(negedge clock);
			waits++;
		end
		check_value("cycles to lsu_valid", 32'(waits), 32'd1);
		check_value("jump_wrong", 32'(jump_wrong), 32'(jw));
		check_value("exu_ready", 32'(exu_ready), 32'd0);
		check_res(e);
		@(posedge clock);
		exu_valid <= 1'b0;
		req       <= stage_pkg::exec_req_t'(~r); // different request on the bus while full
		repeat (hold) begin
			@(negedge clock);
			check_value("jump_wrong", 32'(jump_wrong), 32'd0);
			check_value("exu_ready", 32'(exu_ready), 32'd0);
			check_value("lsu_valid", 32'(lsu_valid), 32'd1);
			check_res(e); // held under stall
			@(posedge clock);
		end
		lsu_ready <= 1'b1;
		@(negedge clock);
		waits = 0;
		while (lsu_valid) begin
			@(negedge clock);
			waits++;
		end
		check_value("cycles to release", 32'(waits), 32'd1);
		check_value("exu_ready", 32'(exu_ready), 32'd1);
		check_value("jump_wrong", 32'(jump_wrong), 32'd0);
	endtask

	task automatic report_test(input string name);
		if (errors == test_errors) begin
			passed++;
			$display("test %s done, no mismatches", name);
		end else begin
			failed++;
			$display("test %s done, %0d mismatches", name, errors - test_errors);
		end
	endtask

	task automatic test_alu();
		int n;
		int f3;
		int k;
		test_errors = errors;
		for (n = 0; n < 4; n++) begin // bit 0 sets funct7 alt and bit 1 picks op over op-imm
			for (f3 = 0; f3 < 8; f3++) begin
				for (k = 0; k < 2; k++) begin
					run_txn(make_req(n[1] ? isa_pkg::class_op : isa_pkg::class_opimm, f3, n[0],
						rand32(), rand32(), rand32()), 0);
				end
			end
		end
		report_test("alu");
	endtask

	task automatic test_branch();
		isa_pkg::word_t bits;
		int             f3;
		int             p;
		test_errors = errors;
		for (f3 = 0; f3 < 8; f3++) begin
			for (p = 0; p < 5; p++) begin
				bits = rand32();
				run_txn(make_req(isa_pkg::class_branch, f3, 1'b0, lhs_vals[p], rhs_vals[p],
					{{19{bits[12]}}, bits[12:2], 2'b00}), 0);
			end
		end
		report_test("branch");
	endtask

	task automatic test_upper_jump();
		stage_pkg::exec_req_t r;
		test_errors = errors;
		run_txn(make_req(isa_pkg::class_lui, 0, 1'b0, rand32(), rand32(),
			rand32() & 32'hffff_f000), 0);
		run_txn(make_req(isa_pkg::class_auipc, 0, 1'b0, rand32(), rand32(),
			rand32() & 32'hffff_f000), 0);
		run_txn(make_req(isa_pkg::class_jal, 0, 1'b0, rand32(), rand32(),
			rand32() & 32'h000f_fffc), 0);
		run_txn(make_req(isa_pkg::class_jalr, 0, 1'b0, rand32(), rand32(),
			rand32() & 32'h0000_0ffc), 0);
		r = make_req(isa_pkg::class_csr, 0, 1'b0, rand32(), rand32(), 32'd0);
		r.ecall       = 1'b1; // trap entry
		r.csr_jump_en = 1'b1;
		r.csr_jump    = rand32() & 32'hffff_fffc;
		run_txn(r, 0);
		r = make_req(isa_pkg::class_jal, 0, 1'b0, rand32(), rand32(), 32'd256);
		r.csr_jump_en = 1'b1;
		r.csr_jump    = rand32() & 32'hffff_fffc;
		run_txn(r, 0);
		report_test("upper_jump");
	endtask

	task automatic test_mem();
		int n;
		test_errors = errors;
		for (n = 0; n < 16; n++) begin
			run_txn(make_req(n[3] ? isa_pkg::class_store : isa_pkg::class_load, n % 8, 1'b0,
				rand32(), rand32(), rand32() & 32'h0000_0fff), 0);
		end
		report_test("mem");
	endtask

	task automatic test_csr();
		stage_pkg::exec_req_t r;
		int                   f3;
		test_errors = errors;
		for (f3 = 0; f3 < 4; f3++) begin
			r = make_req(isa_pkg::class_csr, f3, 1'b0, rand32(), rand32(),
				rand32() & 32'h0000_0fff);
			r.ecall = (f3 == 0);
			run_txn(r, 0);
		end
		report_test("csr");
	endtask

	task automatic test_backpressure();
		int k;
		test_errors = errors;
		for (k = 0; k < 4; k++) begin
			// bne on unequal random operands
			run_txn(make_req(isa_pkg::class_branch, 1, 1'b0, rand32(), rand32(), 32'd64),
				1 + int'(rand32() % 32'd12));
		end
		report_test("backpressure");
	endtask

	initial begin
		rst_n     <= 1'b0;
		exu_valid <= 1'b0;
		lsu_ready <= 1'b0;
		req       <= '0;
		repeat (10) @(posedge clock);
		rst_n <= 1'b1;
		@(negedge clock);
		test_errors = errors;
		check_value("exu_ready", 32'(exu_ready), 32'd1);
		check_value("lsu_valid", 32'(lsu_valid), 32'd0);
		check_value("jump_wrong", 32'(jump_wrong), 32'd0);
		report_test("reset");
		test_alu();
		test_branch();
		test_upper_jump();
		test_mem();
		test_csr();
		test_backpressure();
		$display("%0d tests passed, %0d tests failed", passed, failed);
		if (failed == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
